// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_decode_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,                            // Synchronous, active high
    input  logic     instr_valid_i,                    // Level, sampled each rising edge
    input  word_t    instr_i,
    output logic     dec_valid_o,                      // Record valid, one cycle after input
    output decoded_t dec_o
);

    instr_u    instr;                                  // Format views of instr_i
    word_t     imm;
    ctrl_t     ctrl;
    mem_ctrl_t mem;
    decoded_t  dec_rec;                                // Combinational record before the flop

    // Drop every side effect and keep the payload fields
    function automatic decoded_t bubble(input decoded_t rec);
        decoded_t b;
        b                 = rec;
        b.ctrl.regfile_wr = 1'b0;
        b.ctrl.jump       = 1'b0;
        b.ctrl.jalr       = 1'b0;
        b.ctrl.csr_wr     = 1'b0;
        b.mem.data_rd     = 1'b0;
        b.mem.data_wr     = 1'b0;
        return b;
    endfunction

    assign instr = instr_i;

    imm_gen u_imm_gen (
        .instr_i (instr),
        .imm_o   (imm)
    );

    opcode_ctrl u_opcode_ctrl (
        .instr_i (instr),
        .ctrl_o  (ctrl)
    );

    mem_access_decode u_mem_access_decode (
        .instr_i (instr),
        .mem_o   (mem)
    );

    assign dec_rec = '{
        ctrl:     ctrl,
        mem:      mem,
        imm:      imm,
        rs1:      instr.r.rs1,
        rs2:      instr.r.rs2,
        rd:       instr.r.rd,
        csr_addr: instr.i.imm                          // CSR number sits in the I immediate
    };

    always_ff @(posedge clk_i) begin
        if (rst_i || !instr_valid_i) begin
            dec_valid_o <= 1'b0;
            dec_o       <= bubble(dec_rec);            // Reset or bubble, payload is don't-care
        end else begin
            dec_valid_o <= 1'b1;
            dec_o       <= dec_rec;
        end
    end

endmodule

`default_nettype wire

// File: logic/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_decode_pkg::*; (
    input  instr_u instr_i,                            // Instruction under decode
    output word_t  imm_o                               // Sign-extended immediate
);

    always_comb begin
        imm_o = '0;                                    // No immediate for OP, FENCE, SYSTEM
        case (instr_i.r.opcode)
            OPC_LUI,
            OPC_AUIPC: begin
                imm_o = {instr_i.u.imm, 12'b0};        // Upper 20 bits, low 12 cleared
            end
            OPC_JAL: begin
                imm_o = {{11{instr_i.j.imm_20}},       // Sign extend from bit 20
                         instr_i.j.imm_20,
                         instr_i.j.imm_19_12,
                         instr_i.j.imm_11,
                         instr_i.j.imm_10_1,
                         1'b0};                        // Halfword aligned target
            end
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM: begin
                imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
            end
            OPC_STORE: begin
                imm_o = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
            end
            OPC_BRANCH: begin
                imm_o = {{19{instr_i.b.imm_12}},       // Sign extend from bit 12
                         instr_i.b.imm_12,
                         instr_i.b.imm_11,
                         instr_i.b.imm_10_5,
                         instr_i.b.imm_4_1,
                         1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mem_access_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_decode import rv_decode_pkg::*; (
    input  instr_u    instr_i,                         // Instruction under decode
    output mem_ctrl_t mem_o                            // Data memory control
);

    always_comb begin
        mem_o.data_rd  = 1'b0;
        mem_o.data_wr  = 1'b0;
        mem_o.load_op  = LOAD_LW;                      // Also kept for illegal load funct3
        mem_o.store_op = STORE_SB;
        mem_o.byte_en  = 4'b0000;                      // No lanes unless a legal store
        case (instr_i.r.opcode)
            OPC_LOAD: begin
                mem_o.data_rd = 1'b1;
                case (instr_i.i.funct3)
                    F3_LB:   mem_o.load_op = LOAD_LB;
                    F3_LH:   mem_o.load_op = LOAD_LH;
                    F3_LW:   mem_o.load_op = LOAD_LW;
                    F3_LBU:  mem_o.load_op = LOAD_LBU;
                    F3_LHU:  mem_o.load_op = LOAD_LHU;
                    default: mem_o.load_op = LOAD_LW;
                endcase
            end
            OPC_STORE: begin
                mem_o.data_wr = 1'b1;                  // Strobe even if width is illegal
                case (instr_i.s.funct3)
                    F3_SB: mem_o.byte_en = 4'b0001;
                    F3_SH: begin
                        mem_o.store_op = STORE_SH;
                        mem_o.byte_en  = 4'b0011;      // Low halfword
                    end
                    F3_SW: begin
                        mem_o.store_op = STORE_SW;
                        mem_o.byte_en  = 4'b1111;
                    end
                    default: mem_o.byte_en = 4'b0000;
                endcase
            end
            default: mem_o.data_rd = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/opcode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_ctrl import rv_decode_pkg::*; (
    input  instr_u instr_i,                            // Instruction under decode
    output ctrl_t  ctrl_o                              // Execute and writeback control
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_nz;                                 // Writes to x0 are dropped here

    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;
    assign rd_nz  = |instr_i.r.rd;

    always_comb begin
        ctrl_o.alu_op      = ALU_OP_ADD;               // Default decode is a harmless ADD
        ctrl_o.br_op       = BR_NOOP;
        ctrl_o.data_origin = REGS;
        ctrl_o.data_target = 2'b00;
        ctrl_o.regfile_wr  = 1'b0;
        ctrl_o.jump        = 1'b0;
        ctrl_o.jalr        = 1'b0;
        ctrl_o.use_rs1     = 1'b0;
        ctrl_o.use_rs2     = 1'b0;
        ctrl_o.csr_wr      = 1'b0;
        ctrl_o.csr_op      = '0;
        case (instr_i.r.opcode)
            OPC_LUI: begin
                ctrl_o.data_origin = RS2IMM_RS1;       // x0 + imm
                ctrl_o.regfile_wr  = rd_nz;
            end
            OPC_AUIPC: begin
                ctrl_o.data_target = 2'b11;
                ctrl_o.regfile_wr  = rd_nz;
            end
            OPC_JAL: begin
                ctrl_o.data_target = 2'b11;            // Link value PC+4 into rd
                ctrl_o.jump        = 1'b1;
                ctrl_o.data_origin = RS2IMM_RS1PC;     // PC + imm
                ctrl_o.regfile_wr  = rd_nz;
            end
            OPC_JALR: begin
                ctrl_o.data_target = 2'b11;
                ctrl_o.use_rs1     = 1'b1;
                ctrl_o.jump        = 1'b1;
                ctrl_o.jalr        = 1'b1;             // Target from rs1, not PC
                ctrl_o.data_origin = RS2IMM_RS1PC;
                ctrl_o.regfile_wr  = rd_nz;
            end
            OPC_BRANCH: begin
                ctrl_o.use_rs1 = 1'b1;
                ctrl_o.use_rs2 = 1'b1;
                case (funct3)
                    F3_BEQ:  ctrl_o.br_op = BR_EQ;
                    F3_BNE:  ctrl_o.br_op = BR_NE;
                    F3_BLT:  ctrl_o.br_op = BR_LT;
                    F3_BGE:  ctrl_o.br_op = BR_GE;
                    F3_BLTU: ctrl_o.br_op = BR_LTU;
                    F3_BGEU: ctrl_o.br_op = BR_GEU;
                    default: ctrl_o.br_op = BR_NOOP;   // 010 and 011 are unused
                endcase
            end
            OPC_LOAD: begin
                ctrl_o.use_rs1     = 1'b1;
                ctrl_o.data_origin = RS2IMM_RS1;       // Address is rs1 + imm
                ctrl_o.regfile_wr  = rd_nz;
            end
            OPC_STORE: begin
                ctrl_o.data_target = 2'b01;
                ctrl_o.use_rs1     = 1'b1;
                ctrl_o.use_rs2     = 1'b1;             // Store data
                ctrl_o.data_origin = RS2IMM_RS1;
            end
            OPC_OP_IMM: begin
                ctrl_o.use_rs1     = 1'b1;
                ctrl_o.data_origin = RS2IMM_RS1;
                ctrl_o.regfile_wr  = rd_nz;
                // Immediate bits only count as funct7 for SRLI/SRAI
                ctrl_o.alu_op = {1'b0, (funct3 == F3_SRL_SRA) & funct7[5], funct3};
            end
            OPC_OP: begin
                ctrl_o.use_rs1    = 1'b1;
                ctrl_o.use_rs2    = 1'b1;
                ctrl_o.regfile_wr = rd_nz;
                ctrl_o.alu_op     = {funct7[0], funct7[5], funct3};  // M-ext, SUB/SRA, op
            end
            OPC_SYSTEM: begin
                ctrl_o.csr_wr     = |funct3;           // Zero funct3 is ECALL/EBREAK
                ctrl_o.regfile_wr = rd_nz & (|funct3); // Old CSR value into rd
                ctrl_o.csr_op     = funct3;
                ctrl_o.use_rs1    = ~funct3[2];        // Immediate forms take uimm from rs1 field
            end
            OPC_FENCE: begin
                ctrl_o.alu_op = ALU_OP_ADD;            // Nothing to order in this core
            end
            default: begin
                ctrl_o.alu_op = ALU_OP_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    typedef logic [31:0] word_t;                       // Data and instruction word
    typedef logic [4:0]  reg_addr_t;                   // Register index
    typedef logic [11:0] csr_addr_t;                   // CSR address

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,                       // Decoded as a no-op
        OPC_SYSTEM = 7'b1110011                        // ECALL/EBREAK and CSR access
    } opcode_e;

    localparam logic [2:0] F3_BEQ     = 3'b000;        // Branch conditions
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    localparam logic [2:0] F3_LB      = 3'b000;        // Load widths
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;
    localparam logic [2:0] F3_SB      = 3'b000;        // Store widths
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;        // Only OP-IMM code that takes funct7

    // Six views of the same instruction word, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;                              // Also the CSR address for SYSTEM
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;                            // imm[11:5]
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                            // imm[4:0]
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;                            // Sign bit
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;                            // Sits where S keeps imm[0]
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;                              // imm[31:12]
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;                            // Sign bit
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef logic [4:0] alu_op_t;                      // {M-ext, alternate, funct3}
    localparam alu_op_t ALU_OP_ADD = 5'b00000;

    typedef enum logic [2:0] {
        BR_NOOP, BR_EQ, BR_NE, BR_LT, BR_LTU, BR_GE, BR_GEU
    } br_op_e;

    typedef enum logic [2:0] {
        LOAD_LB, LOAD_LH, LOAD_LW, LOAD_LBU, LOAD_LHU
    } load_op_e;

    typedef enum logic [1:0] {
        STORE_SB, STORE_SH, STORE_SW
    } store_op_e;

    typedef enum logic [1:0] {
        REGS, RS2IMM_RS1, RS2IMM_RS1PC                 // Operand origin for execute
    } data_origin_e;

    typedef logic [2:0] csr_op_t;                      // Bit 2 immediate form, 01/10/11 RW/RS/RC

    typedef struct packed {
        alu_op_t      alu_op;
        br_op_e       br_op;
        data_origin_e data_origin;
        logic [1:0]   data_target;
        logic         regfile_wr;
        logic         jump;
        logic         jalr;
        logic         use_rs1;
        logic         use_rs2;
        logic         csr_wr;
        csr_op_t      csr_op;
    } ctrl_t;

    typedef struct packed {
        logic      data_rd;
        logic      data_wr;
        load_op_e  load_op;
        store_op_e store_op;
        logic [3:0] byte_en;
    } mem_ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        mem_ctrl_t mem;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        csr_addr_t csr_addr;
    } decoded_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_decode.f --top-module decode_stage_tb \
    -Mdir obj_dir -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/decode_stage_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: rv_decode.f
logic/rv_decode_pkg.sv
logic/imm_gen.sv
logic/opcode_ctrl.sv
logic/mem_access_decode.sv
logic/decode_stage.sv
testbench/decode_stage_tb.sv

// File: testbench/decode_cases.txt
# name instr imm ctrl_t mem_ctrl_t rs1 rs2 rd csr_addr
# hex except rs1 rs2 rd in decimal
lui_neg      FFFFF2B7 FFFFF000 000900 080 31 31  5 FFF
auipc        12345097 12345000 000700 080  8  3  1 123
jal_neg      FFDFF0EF FFFFFFFC 001780 080 31 29  1 FFD
jalr         008100E7 00000008 0017E0 080  2  8  1 008
jalr_x0_neg  80018067 FFFFF800 0016E0 080  3  0  0 800
beq          00208463 00000008 002030 080  1  2  8 002
bne_neg      FE4198E3 FFFFFFF0 004030 080  3  4 17 FE4
blt          0062C263 00000004 006030 080  5  6  4 006
bge          0062D263 00000004 00A030 080  5  6  4 006
bltu         0062E263 00000004 008030 080  5  6  4 006
bgeu         0062F263 00000004 00C030 080  5  6  4 006
br_f3_010    0062A263 00000004 000030 080  5  6  4 006
lb_neg       FFF40383 FFFFFFFF 000920 400  8 31  7 FFF
lh           00241383 00000002 000920 440  8  2  7 002
lw           00242383 00000002 000920 480  8  2  7 002
lbu          00244383 00000002 000920 4C0  8  2  7 002
lhu          00245383 00000002 000920 500  8  2  7 002
ld_f3_011    00243383 00000002 000920 480  8  2  7 002
sb_neg       FE950E23 FFFFFFFC 000A30 281 10  9 28 FE9
sh           00951323 00000006 000A30 293 10  9  6 009
sw           00952323 00000006 000A30 2AF 10  9  6 009
st_f3_011    00953323 00000006 000A30 280 10  9  6 009
addi_neg     FFB60593 FFFFFFFB 000920 080 12 27 11 FFB
srai         40365593 00000403 0D0920 080 12  3 11 403
xori_neg     C0064593 FFFFFC00 040920 080 12  0 11 C00
sub          40F706B3 00000000 080130 080 14 15 13 40F
sra          40F756B3 00000000 0D0130 080 14 15 13 40F
mul          02F706B3 00000000 100130 080 14 15 13 02F
div          02F746B3 00000000 140130 080 14 15 13 02F
add_x0       00F70033 00000000 000030 080 14 15  0 00F
csrrw        300110F3 00000000 000129 080  2  0  1 300
csrrsi       3402E1F3 00000000 00010E 080  5  0  3 340
ecall        00000073 00000000 000020 080  0  0  0 000
fence        0FF0000F 00000000 000000 080  0 31  0 0FF

// File: testbench/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb import rv_decode_pkg::*; ();

    localparam int DRIVE_DLY = 5;                      // Inputs change this long after posedge
    localparam int NAME_LEN  = 16;
    localparam word_t RESET_WORD = 32'h008100E7;       // jalr x1, raises regfile_wr, jump, jalr

    typedef logic [8*NAME_LEN-1:0] name_t;

    typedef struct packed {
        word_t     instr;
        word_t     imm;
        ctrl_t     ctrl;
        mem_ctrl_t mem;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        csr_addr_t csr;
    } case_t;

    logic     clk_i;
    logic     rst_i;
    logic     instr_valid_i;
    word_t    instr_i;
    logic     dec_valid_o;
    decoded_t dec_o;

    name_t  names[$];                                  // Test names, same order as cases
    case_t  cases[$];
    integer seed = 32'h0cf0f7f9;
    integer mismatch_cnt = 0;
    integer other_cnt = 0;
    integer cycle_cnt = 0;
    integer cycle_limit = 13;                          // Raised once the case count is known

    decode_stage dut_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;                    // 100 ns period
    end

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            other_cnt = other_cnt + 1;
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            finish_run();
        end
    end

    task automatic check_valid(input name_t name, input logic exp, input logic act);
        if (exp !== act) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch %0s flag: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_ctrl(input name_t name, input ctrl_t exp, input ctrl_t act);
        if (exp !== act) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch %0s ctrl: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mem(input name_t name, input mem_ctrl_t exp, input mem_ctrl_t act);
        if (exp !== act) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch %0s mem: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_imm(input name_t name, input word_t exp, input word_t act);
        if (exp !== act) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch %0s imm: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_regs(input name_t name, input reg_addr_t exp_rs1,
                              input reg_addr_t exp_rs2, input reg_addr_t exp_rd,
                              input reg_addr_t act_rs1, input reg_addr_t act_rs2,
                              input reg_addr_t act_rd);
        if (exp_rs1 !== act_rs1 || exp_rs2 !== act_rs2 || exp_rd !== act_rd) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch %0s regs: expected %0d/%0d/%0d, actual %0d/%0d/%0d", name,
                     exp_rs1, exp_rs2, exp_rd, act_rs1, act_rs2, act_rd);
        end
    endtask

    task automatic check_csr(input name_t name, input csr_addr_t exp, input csr_addr_t act);
        if (exp !== act) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch %0s csr_addr: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Valid and every side-effect strobe must be low
    task automatic check_idle(input name_t name);
        check_valid(name, 1'b0, dec_valid_o);
        check_valid(name, 1'b0, dec_o.ctrl.regfile_wr);
        check_valid(name, 1'b0, dec_o.ctrl.jump);
        check_valid(name, 1'b0, dec_o.ctrl.jalr);
        check_valid(name, 1'b0, dec_o.ctrl.csr_wr);
        check_valid(name, 1'b0, dec_o.mem.data_rd);
        check_valid(name, 1'b0, dec_o.mem.data_wr);
    endtask

    task automatic check_case(input int idx);
        case_t c;
        c = cases[idx];
        check_valid(names[idx], 1'b1, dec_valid_o);
        check_ctrl(names[idx], c.ctrl, dec_o.ctrl);
        check_mem(names[idx], c.mem, dec_o.mem);
        check_imm(names[idx], c.imm, dec_o.imm);
        check_regs(names[idx], c.rs1, c.rs2, c.rd, dec_o.rs1, dec_o.rs2, dec_o.rd);
        check_csr(names[idx], c.csr, dec_o.csr_addr);
    endtask

    // Lines starting with # are column notes
    task automatic read_cases(input integer fd);
        string  line;
        name_t  name;
        case_t  c;
        logic [31:0] t_instr, t_imm, t_ctrl, t_mem, t_csr;
        integer t_rs1, t_rs2, t_rd;
        integer n;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line.getc(0) == "#") begin
                continue;                              // Comment or blank line
            end
            n = $sscanf(line, "%s %h %h %h %h %d %d %d %h", name, t_instr, t_imm, t_ctrl,
                        t_mem, t_rs1, t_rs2, t_rd, t_csr);
            if (n != 9) begin
                other_cnt = other_cnt + 1;
                $display("Malformed line in case file: %0s", line);
                continue;
            end
            c.instr = t_instr;
            c.imm   = t_imm;
            c.ctrl  = t_ctrl[20:0];
            c.mem   = t_mem[10:0];
            c.rs1   = t_rs1[4:0];
            c.rs2   = t_rs2[4:0];
            c.rd    = t_rd[4:0];
            c.csr   = t_csr[11:0];
            names.push_back(name);
            cases.push_back(c);
        end
    endtask

    // One step per cycle; a result is checked one edge after issue
    task automatic run_tests();
        int     pending[$];                            // Case index, or -1 for a bubble
        int     item;
        int     next;
        logic   bubble_due;
        integer r;
        next       = 0;
        bubble_due = 1'b0;
        while (next < cases.size() || pending.size() > 0) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            if (pending.size() > 0) begin
                item = pending.pop_front();
                if (item < 0) begin
                    check_idle("bubble");
                end else begin
                    check_case(item);
                end
            end
            if (next < cases.size() && bubble_due) begin
                instr_valid_i = 1'b0;                  // Old word stays, strobes must clear
                pending.push_back(-1);
                bubble_due = 1'b0;
            end else if (next < cases.size()) begin
                instr_valid_i = 1'b1;
                instr_i       = cases[next].instr;
                pending.push_back(next);
                next       = next + 1;
                r          = $random(seed);
                bubble_due = r[0];
            end else begin
                instr_valid_i = 1'b0;
            end
        end
    endtask

    initial begin
        integer fd;
        rst_i         = 1'b1;
        instr_valid_i = 1'b1;                          // Reset must override a valid word
        instr_i       = RESET_WORD;
        fd = $fopen("testbench/decode_cases.txt", "r");
        if (fd == 0) begin
            other_cnt = other_cnt + 1;
            $display("Cannot open case file testbench/decode_cases.txt");
            finish_run();
        end else begin
            read_cases(fd);
            $fclose(fd);
            if (cases.size() == 0) begin
                other_cnt = other_cnt + 1;
                $display("Case file testbench/decode_cases.txt holds no test cases");
            end
            cycle_limit = 3 + 2 * cases.size() + 10;
            repeat (3) @(posedge clk_i);
            #DRIVE_DLY;
            check_idle("reset");
            rst_i         = 1'b0;
            instr_valid_i = 1'b0;
            run_tests();
            finish_run();
        end
    end

endmodule

`default_nettype wire
